//--- Bender.yml
package:
  name: issue_stage

sources:
  - include_dirs:
      - common
    files:
      - common/issue_pkg.sv
      - issue/inst_decoder.sv
      - issue/dual_issue.sv
      - verilog/inst_queue.sv
      - verilog/issue_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - verification/issue_checker.sv
      - verification/issue_tb.sv

//--- common/issue_consts.svh
`ifndef ISSUE_CONSTS_SVH
`define ISSUE_CONSTS_SVH

`define ISSUE_QUEUE_DEPTH 8

// primary opcodes
`define OP_SPECIAL  6'b000000
`define OP_REGIMM   6'b000001
`define OP_J        6'b000010
`define OP_JAL      6'b000011
`define OP_BEQ      6'b000100
`define OP_BNE      6'b000101
`define OP_BLEZ     6'b000110
`define OP_BGTZ     6'b000111
`define OP_ADDI     6'b001000
`define OP_ADDIU    6'b001001
`define OP_SLTI     6'b001010
`define OP_SLTIU    6'b001011
`define OP_ANDI     6'b001100
`define OP_ORI      6'b001101
`define OP_XORI     6'b001110
`define OP_LUI      6'b001111
`define OP_COP0     6'b010000
`define OP_LB       6'b100000
`define OP_LH       6'b100001
`define OP_LW       6'b100011
`define OP_LBU      6'b100100
`define OP_LHU      6'b100101
`define OP_SB       6'b101000
`define OP_SH       6'b101001
`define OP_SW       6'b101011
`define OP_CACHE    6'b101111

// SPECIAL function codes
`define FUNC_SLL    6'b000000
`define FUNC_SRL    6'b000010
`define FUNC_SRA    6'b000011
`define FUNC_JR     6'b001000
`define FUNC_JALR   6'b001001
`define FUNC_MFHI   6'b010000
`define FUNC_MFLO   6'b010010
`define FUNC_MULT   6'b011000
`define FUNC_MULTU  6'b011001
`define FUNC_ADD    6'b100000
`define FUNC_ADDU   6'b100001
`define FUNC_SUB    6'b100010
`define FUNC_SUBU   6'b100011
`define FUNC_AND    6'b100100
`define FUNC_OR     6'b100101
`define FUNC_XOR    6'b100110
`define FUNC_NOR    6'b100111
`define FUNC_SLT    6'b101010
`define FUNC_SLTU   6'b101011

// COP0 function codes, with rs = CO
`define FUNC_TLBR   6'b000001
`define FUNC_TLBWI  6'b000010
`define FUNC_TLBP   6'b001000

// REGIMM rt field and COP0 rs field
`define RT_BLTZ     5'b00000
`define RT_BGEZ     5'b00001
`define RT_BLTZAL   5'b10000
`define RT_BGEZAL   5'b10001
`define RS_MF       5'b00000
`define RS_MT       5'b00100
`define RS_CO       5'b10000

`endif

//--- common/issue_pkg.sv
package issue_pkg;

    // one record per fetched instruction, 99 bits
    typedef struct packed {
        logic        pred_taken;
        logic [31:0] pred_target;
        logic        itlb_refill;
        logic        itlb_invalid;
        logic [31:0] pc;
        logic [31:0] inst;
    } fetch_entry_t;

    // decoded instruction as handed to the next stage
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] inst;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sa;
        logic        w_reg_ena;
        logic [4:0]  w_reg_dst;
        logic [15:0] imme;
        logic [25:0] j_imme;
        logic        pred_taken;
        logic [31:0] pred_target;
        // instruction class
        logic        is_branch;
        logic        is_j_imme;
        logic        is_jr;
        logic        is_ls;
        logic        is_mul;
        logic        is_hilo;
        logic        is_cop0;
        logic        is_tlbp;
        logic        is_tlbr;
        logic        is_tlbwi;
        logic        is_cache;
        logic        is_check_ov;
        logic        is_ri;
        // fetch side exceptions
        logic        is_inst_adel;
        logic        itlb_refill;
        logic        itlb_invalid;
        // filled by the issue logic
        logic        in_delay_slot;
        logic        is_refetch;
    } issue_slot_t;

    // performance counters
    typedef logic [31:0] issue_count_t;

endpackage

//--- filelist.f
+incdir+common
common/issue_pkg.sv
issue/inst_decoder.sv
issue/dual_issue.sv
verilog/inst_queue.sv
verilog/issue_top.sv
verification/issue_checker.sv
verification/issue_tb.sv

//--- issue/dual_issue.sv
`timescale 1ns/1ps

module dual_issue (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stall,
    input  logic                  cls_refetch,
    input  issue_pkg::issue_slot_t dec_0,
    input  issue_pkg::issue_slot_t dec_1,
    input  logic                  head_0_ok,
    input  logic                  head_1_ok,
    output logic                  pop_0,
    output logic                  pop_1,
    output issue_pkg::issue_slot_t slot_0,
    output issue_pkg::issue_slot_t slot_1
);

    logic in_ds;
    logic in_ds_next;
    logic refetch;
    logic refetch_next;
    logic jmp_0;
    logic jmp_1;
    logic tlb_0;
    logic raw_conflict;
    logic block_1;

    // performance probes, single and paired issues
    issue_pkg::issue_count_t single_count;
    issue_pkg::issue_count_t pair_count;

    assign jmp_0 = dec_0.is_branch | dec_0.is_j_imme | dec_0.is_jr;
    assign jmp_1 = dec_1.is_branch | dec_1.is_j_imme | dec_1.is_jr;
    assign tlb_0 = dec_0.is_tlbp | dec_0.is_tlbr | dec_0.is_tlbwi;

    // slot 1 reads what slot 0 writes
    assign raw_conflict = dec_0.w_reg_ena &
        (((dec_1.rs == dec_0.w_reg_dst) & (dec_1.rs != 5'd0)) |
         ((dec_1.rt == dec_0.w_reg_dst) & (dec_1.rt != 5'd0)));

    assign block_1 =
        in_ds               |
        raw_conflict        |
        jmp_1               |
        dec_1.is_hilo       |
        dec_1.is_mul        |
        dec_1.is_cop0       |
        dec_1.is_ls         |
        dec_1.is_ri         |
        dec_1.is_check_ov   |
        dec_1.is_inst_adel  |
        dec_1.itlb_refill   |
        dec_1.itlb_invalid  |
        dec_1.is_cache      |
        tlb_0;

    assign pop_0 = ~stall & head_0_ok;
    assign pop_1 = pop_0 & head_1_ok & ~block_1;

    // held through a stall
    assign in_ds_next = stall ? in_ds : (pop_0 & jmp_0 & ~pop_1);

    // only slot 0 can carry a tlb op
    assign refetch_next = refetch ? ~cls_refetch :
        (pop_0 & (dec_0.is_tlbr | dec_0.is_tlbwi));

    always_ff @(posedge clk) begin
        if (rst) begin
            in_ds   <= 1'b0;
            refetch <= 1'b0;
        end else begin
            in_ds   <= in_ds_next;
            refetch <= refetch_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            single_count <= '0;
            pair_count   <= '0;
        end else begin
            if (pop_0 && !pop_1) begin
                single_count <= single_count + 32'd1;
            end
            if (pop_1) begin
                pair_count <= pair_count + 32'd1;
            end
        end
    end

    always_comb begin
        slot_0               = dec_0;
        slot_0.valid         = pop_0;
        slot_0.in_delay_slot = in_ds;
        slot_0.is_refetch    = refetch;

        slot_1               = dec_1;
        slot_1.valid         = pop_1;
        slot_1.in_delay_slot = jmp_0;
        slot_1.is_refetch    = refetch;
    end

endmodule

//--- issue/inst_decoder.sv
`timescale 1ns/1ps

`include "issue_consts.svh"

module inst_decoder (
    input  issue_pkg::fetch_entry_t entry,
    output issue_pkg::issue_slot_t  slot
);

    logic [5:0] op;
    logic [5:0] func;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;

    assign op   = entry.inst[31:26];
    assign rs   = entry.inst[25:21];
    assign rt   = entry.inst[20:16];
    assign rd   = entry.inst[15:11];
    assign func = entry.inst[5:0];

    always_comb begin
        slot = '0;

        // raw fields, whatever the instruction
        slot.pc           = entry.pc;
        slot.inst         = entry.inst;
        slot.rs           = rs;
        slot.rt           = rt;
        slot.rd           = rd;
        slot.sa           = entry.inst[10:6];
        slot.imme         = entry.inst[15:0];
        slot.j_imme       = entry.inst[25:0];
        slot.pred_taken   = entry.pred_taken;
        slot.pred_target  = entry.pred_target;
        slot.itlb_refill  = entry.itlb_refill;
        slot.itlb_invalid = entry.itlb_invalid;
        slot.is_inst_adel = entry.pc[1:0] != 2'b00;

        case (op)
            `OP_SPECIAL: begin
                case (func)
                    `FUNC_ADD, `FUNC_SUB: begin
                        slot.w_reg_ena   = 1'b1;
                        slot.w_reg_dst   = rd;
                        slot.is_check_ov = 1'b1;
                    end
                    `FUNC_ADDU, `FUNC_SUBU, `FUNC_SLT, `FUNC_SLTU,
                    `FUNC_AND, `FUNC_OR, `FUNC_XOR, `FUNC_NOR,
                    `FUNC_SLL, `FUNC_SRL, `FUNC_SRA: begin
                        slot.w_reg_ena = 1'b1;
                        slot.w_reg_dst = rd;
                    end
                    `FUNC_JR: slot.is_jr = 1'b1;
                    `FUNC_JALR: begin
                        slot.is_jr     = 1'b1;
                        slot.w_reg_ena = 1'b1;
                        slot.w_reg_dst = rd;
                    end
                    `FUNC_MFHI, `FUNC_MFLO: begin
                        slot.is_hilo   = 1'b1;
                        slot.w_reg_ena = 1'b1;
                        slot.w_reg_dst = rd;
                    end
                    `FUNC_MULT, `FUNC_MULTU: slot.is_mul = 1'b1;
                    default: slot.is_ri = 1'b1;
                endcase
            end
            `OP_REGIMM: begin
                case (rt)
                    `RT_BLTZ, `RT_BGEZ: slot.is_branch = 1'b1;
                    `RT_BLTZAL, `RT_BGEZAL: begin
                        slot.is_branch = 1'b1;
                        slot.w_reg_ena = 1'b1;
                        slot.w_reg_dst = 5'd31;
                    end
                    default: slot.is_ri = 1'b1;
                endcase
            end
            `OP_J: slot.is_j_imme = 1'b1;
            `OP_JAL: begin
                slot.is_j_imme = 1'b1;
                slot.w_reg_ena = 1'b1;
                slot.w_reg_dst = 5'd31;
            end
            `OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ: slot.is_branch = 1'b1;
            `OP_ADDI: begin
                slot.w_reg_ena   = 1'b1;
                slot.w_reg_dst   = rt;
                slot.is_check_ov = 1'b1;
            end
            `OP_ADDIU, `OP_SLTI, `OP_SLTIU, `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI: begin
                slot.w_reg_ena = 1'b1;
                slot.w_reg_dst = rt;
            end
            `OP_LB, `OP_LH, `OP_LW, `OP_LBU, `OP_LHU: begin
                slot.is_ls     = 1'b1;
                slot.w_reg_ena = 1'b1;
                slot.w_reg_dst = rt;
            end
            `OP_SB, `OP_SH, `OP_SW: slot.is_ls = 1'b1;
            `OP_CACHE: slot.is_cache = 1'b1;
            `OP_COP0: begin
                // tlb ops count as cop0 too
                slot.is_cop0 = 1'b1;
                case (rs)
                    `RS_MF: begin
                        slot.w_reg_ena = 1'b1;
                        slot.w_reg_dst = rt;
                    end
                    `RS_MT: ;
                    `RS_CO: begin
                        case (func)
                            `FUNC_TLBP:  slot.is_tlbp  = 1'b1;
                            `FUNC_TLBR:  slot.is_tlbr  = 1'b1;
                            `FUNC_TLBWI: slot.is_tlbwi = 1'b1;
                            default:     slot.is_ri    = 1'b1;
                        endcase
                    end
                    default: slot.is_ri = 1'b1;
                endcase
            end
            default: slot.is_ri = 1'b1;
        endcase
    end

endmodule

//--- verification/issue_checker.sv
`timescale 1ns/1ps

module issue_checker (
    input logic clk,
    input logic rst,
    input logic push,
    input logic full,
    input logic stall,
    input logic pop_0,
    input logic pop_1
);

    // fetch has to hold off on full
    no_push_when_full: assert property (@(posedge clk) disable iff (rst) !(push && full))
        else $error("push while the queue is full");

    pop_1_needs_pop_0: assert property (@(posedge clk) disable iff (rst) pop_1 |-> pop_0)
        else $error("second entry popped without the first");

    no_pop_in_stall: assert property (@(posedge clk) disable iff (rst) stall |-> !pop_0)
        else $error("entry popped while stalled");

endmodule

// queue side sees no stall
bind inst_queue issue_checker i_queue_checker (
    .clk   (clk),
    .rst   (rst),
    .push  (push),
    .full  (full),
    .stall (1'b0),
    .pop_0 (pop_0),
    .pop_1 (pop_1)
);

bind dual_issue issue_checker i_issue_checker (
    .clk   (clk),
    .rst   (rst),
    .push  (1'b0),
    .full  (1'b0),
    .stall (stall),
    .pop_0 (pop_0),
    .pop_1 (pop_1)
);

//--- verification/issue_tb.sv
`timescale 1ns/1ps

`include "issue_consts.svh"

module issue_tb;

    localparam int NUM_CYCLES     = 2000;
    localparam int TIMEOUT_CYCLES = 2 * NUM_CYCLES;

    logic                    clk = 1'b0;
    logic                    rst;
    logic                    push;
    issue_pkg::fetch_entry_t push_entry;
    logic                    stall;
    logic                    cls_refetch;
    logic                    full;
    issue_pkg::issue_slot_t  slot_0;
    issue_pkg::issue_slot_t  slot_1;

    // reference model state
    issue_pkg::fetch_entry_t model_q[$];
    logic        model_ds;
    logic        model_refetch;
    logic [31:0] next_pc;
    int          cycle_count = 0;
    int          pushed;
    int          single_issues;
    int          pair_issues;

    logic [5:0] spec_funcs [19] = '{`FUNC_SLL, `FUNC_SRL, `FUNC_SRA, `FUNC_JR, `FUNC_JALR,
        `FUNC_MFHI, `FUNC_MFLO, `FUNC_MULT, `FUNC_MULTU, `FUNC_ADD, `FUNC_ADDU, `FUNC_SUB,
        `FUNC_SUBU, `FUNC_AND, `FUNC_OR, `FUNC_XOR, `FUNC_NOR, `FUNC_SLT, `FUNC_SLTU};
    logic [5:0] main_ops [24] = '{`OP_REGIMM, `OP_J, `OP_JAL, `OP_BEQ, `OP_BNE, `OP_BLEZ,
        `OP_BGTZ, `OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU, `OP_ANDI, `OP_ORI, `OP_XORI,
        `OP_LUI, `OP_LB, `OP_LH, `OP_LW, `OP_LBU, `OP_LHU, `OP_SB, `OP_SH, `OP_SW, `OP_CACHE};
    logic [4:0] cop0_rs [4] = '{`RS_MF, `RS_MT, `RS_CO, 5'b00010};
    logic [5:0] tlb_funcs [3] = '{`FUNC_TLBP, `FUNC_TLBR, `FUNC_TLBWI};

    issue_top i_dut (
        .clk         (clk),
        .rst         (rst),
        .push        (push),
        .push_entry  (push_entry),
        .stall       (stall),
        .cls_refetch (cls_refetch),
        .full        (full),
        .slot_0      (slot_0),
        .slot_1      (slot_1)
    );

    always #20 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            abort_run($sformatf("run did not finish within %0d cycles", TIMEOUT_CYCLES));
        end
    end

    task automatic compare_slot(input string name, input issue_pkg::issue_slot_t exp,
                                input issue_pkg::issue_slot_t act);
        if (exp.valid ? (act !== exp) : (act.valid !== 1'b0)) begin
            abort_run($sformatf("mismatch %s: expected %h, got %h", name, exp, act));
        end
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("mismatch %s: expected %h, got %h", name, exp, act));
        end
    endtask

    task automatic compare_count(input string name, input issue_pkg::issue_count_t exp,
                                 input issue_pkg::issue_count_t act);
        if (act !== exp) begin
            abort_run($sformatf("mismatch %s: expected %h, got %h", name, exp, act));
        end
    endtask

    // registers come from a small pool so that pairs often collide
    function automatic logic [31:0] gen_inst();
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [5:0]  op;
        logic [5:0]  fn;
        int unsigned pick;
        rs   = 5'($urandom_range(0, 3));
        rt   = 5'($urandom_range(0, 3));
        fn   = 6'($urandom);
        pick = $urandom_range(0, 99);
        if (pick < 40) begin
            op = `OP_SPECIAL;
            fn = spec_funcs[$urandom_range(0, 18)];
        end else if (pick < 80) begin
            op = main_ops[$urandom_range(0, 23)];
            if (op == `OP_REGIMM) begin
                rt[4] = 1'($urandom_range(0, 1));
            end
        end else if (pick < 92) begin
            op = `OP_COP0;
            rs = cop0_rs[$urandom_range(0, 3)];
            if (rs == `RS_CO && $urandom_range(0, 3) != 0) begin
                fn = tlb_funcs[$urandom_range(0, 2)];
            end
        end else begin
            return $urandom;
        end
        return {op, rs, rt, 5'($urandom_range(0, 3)), 5'($urandom), fn};
    endfunction

    function automatic issue_pkg::issue_slot_t model_decode(input issue_pkg::fetch_entry_t e);
        issue_pkg::issue_slot_t s;
        logic [5:0] op;
        logic [5:0] fn;
        logic       sp;
        logic       imm_alu;
        logic       wr_rd;
        logic       wr_rt;
        logic       link;
        logic       known;
        op = e.inst[31:26];
        fn = e.inst[5:0];
        sp = op == `OP_SPECIAL;
        s = '0;
        s.pc = e.pc;
        s.inst = e.inst;
        s.rs = e.inst[25:21];
        s.rt = e.inst[20:16];
        s.rd = e.inst[15:11];
        s.sa = e.inst[10:6];
        s.imme = e.inst[15:0];
        s.j_imme = e.inst[25:0];
        s.pred_taken = e.pred_taken;
        s.pred_target = e.pred_target;
        s.itlb_refill = e.itlb_refill;
        s.itlb_invalid = e.itlb_invalid;
        s.is_inst_adel = |e.pc[1:0];
        imm_alu = op inside {`OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU, `OP_ANDI, `OP_ORI,
                             `OP_XORI, `OP_LUI};
        s.is_check_ov = (sp && (fn == `FUNC_ADD || fn == `FUNC_SUB)) || op == `OP_ADDI;
        s.is_jr = sp && (fn == `FUNC_JR || fn == `FUNC_JALR);
        s.is_hilo = sp && (fn == `FUNC_MFHI || fn == `FUNC_MFLO);
        s.is_mul = sp && (fn == `FUNC_MULT || fn == `FUNC_MULTU);
        s.is_j_imme = op == `OP_J || op == `OP_JAL;
        s.is_branch = op inside {`OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ} || (op == `OP_REGIMM
            && s.rt inside {`RT_BLTZ, `RT_BGEZ, `RT_BLTZAL, `RT_BGEZAL});
        s.is_ls = op inside {`OP_LB, `OP_LH, `OP_LW, `OP_LBU, `OP_LHU, `OP_SB, `OP_SH, `OP_SW};
        s.is_cache = op == `OP_CACHE;
        s.is_cop0 = op == `OP_COP0;
        s.is_tlbp = s.is_cop0 && s.rs == `RS_CO && fn == `FUNC_TLBP;
        s.is_tlbr = s.is_cop0 && s.rs == `RS_CO && fn == `FUNC_TLBR;
        s.is_tlbwi = s.is_cop0 && s.rs == `RS_CO && fn == `FUNC_TLBWI;
        wr_rd = sp && fn inside {`FUNC_ADD, `FUNC_ADDU, `FUNC_SUB, `FUNC_SUBU, `FUNC_AND,
            `FUNC_OR, `FUNC_XOR, `FUNC_NOR, `FUNC_SLT, `FUNC_SLTU, `FUNC_SLL, `FUNC_SRL,
            `FUNC_SRA, `FUNC_JALR, `FUNC_MFHI, `FUNC_MFLO};
        wr_rt = imm_alu || op inside {`OP_LB, `OP_LH, `OP_LW, `OP_LBU, `OP_LHU}
            || (s.is_cop0 && s.rs == `RS_MF);
        link = op == `OP_JAL || (op == `OP_REGIMM && s.rt inside {`RT_BLTZAL, `RT_BGEZAL});
        s.w_reg_ena = wr_rd || wr_rt || link;
        s.w_reg_dst = link ? 5'd31 : (wr_rd ? s.rd : (wr_rt ? s.rt : 5'd0));
        known = (sp && (wr_rd || s.is_jr || s.is_mul)) || s.is_branch || s.is_j_imme
            || s.is_ls || s.is_cache || imm_alu || s.is_tlbp || s.is_tlbr || s.is_tlbwi
            || (s.is_cop0 && (s.rs == `RS_MF || s.rs == `RS_MT));
        s.is_ri = !known;
        return s;
    endfunction

    function automatic logic is_jump(input issue_pkg::issue_slot_t s);
        return s.is_branch || s.is_j_imme || s.is_jr;
    endfunction

    function automatic logic pair_allowed(input logic ds, input issue_pkg::issue_slot_t s0,
                                          input issue_pkg::issue_slot_t s1);
        logic reads_dst;
        reads_dst = s0.w_reg_ena && ((s1.rs != 5'd0 && s1.rs == s0.w_reg_dst)
            || (s1.rt != 5'd0 && s1.rt == s0.w_reg_dst));
        return !(ds || reads_dst || is_jump(s1) || s1.is_hilo || s1.is_mul || s1.is_cop0
            || s1.is_ls || s1.is_ri || s1.is_check_ov || s1.is_inst_adel || s1.itlb_refill
            || s1.itlb_invalid || s1.is_cache || s0.is_tlbp || s0.is_tlbr || s0.is_tlbwi);
    endfunction

    task automatic drive_inputs(input logic busy);
        push = busy && model_q.size() < `ISSUE_QUEUE_DEPTH && $urandom_range(0, 7) != 0;
        stall = busy && $urandom_range(0, 2) == 0;
        cls_refetch = $urandom_range(0, 7) == 0;
        push_entry.inst = gen_inst();
        // now and then a misaligned pc
        push_entry.pc = ($urandom_range(0, 31) == 0) ? (next_pc | 32'($urandom_range(1, 3)))
                                                     : next_pc;
        push_entry.pred_taken = 1'($urandom);
        push_entry.pred_target = $urandom;
        push_entry.itlb_refill = $urandom_range(0, 31) == 0;
        push_entry.itlb_invalid = $urandom_range(0, 31) == 0;
        if (push) begin
            next_pc = next_pc + 32'd4;
        end
    endtask

    task automatic check_and_step();
        issue_pkg::issue_slot_t exp_0;
        issue_pkg::issue_slot_t exp_1;
        exp_0 = '0;
        exp_1 = '0;
        if (model_q.size() > 0) begin
            exp_0 = model_decode(model_q[0]);
        end
        if (model_q.size() > 1) begin
            exp_1 = model_decode(model_q[1]);
        end
        exp_0.valid = !stall && model_q.size() > 0;
        exp_1.valid = exp_0.valid && model_q.size() > 1 && pair_allowed(model_ds, exp_0, exp_1);
        exp_0.in_delay_slot = model_ds;
        exp_1.in_delay_slot = is_jump(exp_0);
        exp_0.is_refetch = model_refetch;
        exp_1.is_refetch = model_refetch;
        compare_bit("full", model_q.size() == `ISSUE_QUEUE_DEPTH, full);
        compare_slot("slot_0", exp_0, slot_0);
        compare_slot("slot_1", exp_1, slot_1);
        // advance the model to the next edge
        if (model_refetch) begin
            model_refetch = !cls_refetch;
        end else begin
            model_refetch = (exp_0.valid && (exp_0.is_tlbr || exp_0.is_tlbwi))
                || (exp_1.valid && (exp_1.is_tlbr || exp_1.is_tlbwi));
        end
        // set by a jump issued alone, kept over a stall, cleared otherwise
        if (!stall) begin
            model_ds = exp_0.valid && is_jump(exp_0) && !exp_1.valid;
        end
        if (exp_0.valid) begin
            void'(model_q.pop_front());
        end
        if (exp_1.valid) begin
            void'(model_q.pop_front());
            pair_issues = pair_issues + 1;
        end else if (exp_0.valid) begin
            single_issues = single_issues + 1;
        end
        if (push) begin
            model_q.push_back(push_entry);
            pushed = pushed + 1;
        end
    endtask

    initial begin
        void'($urandom(33876));
        rst = 1'b1;
        push = 1'b0;
        push_entry = '0;
        stall = 1'b0;
        cls_refetch = 1'b0;
        model_ds = 1'b0;
        model_refetch = 1'b0;
        next_pc = 32'hbfc0_0000;
        pushed = 0;
        single_issues = 0;
        pair_issues = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < NUM_CYCLES; i++) begin
            drive_inputs(1'b1);
            #1;
            check_and_step();
            @(negedge clk);
        end
        // drain what is left without pushes or stalls
        while (model_q.size() != 0) begin
            drive_inputs(1'b0);
            #1;
            check_and_step();
            @(negedge clk);
        end
        // issue counters inside the issue logic
        compare_count("single_count", single_issues, i_dut.i_issue.single_count);
        compare_count("pair_count", pair_issues, i_dut.i_issue.pair_count);
        $display("all tests passed");
        $finish;
    end

endmodule

//--- verilog/inst_queue.sv
`timescale 1ns/1ps

`include "issue_consts.svh"

module inst_queue #(
    parameter int DEPTH = `ISSUE_QUEUE_DEPTH
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    push,
    input  issue_pkg::fetch_entry_t push_entry,
    input  logic                    pop_0,
    input  logic                    pop_1,
    output issue_pkg::fetch_entry_t head_0,
    output issue_pkg::fetch_entry_t head_1,
    output logic                    head_0_ok,
    output logic                    head_1_ok,
    output logic                    full
);

    localparam int PTR_W = $clog2(DEPTH);

    issue_pkg::fetch_entry_t mem [DEPTH];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] rd_ptr_1;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W:0]   count;
    logic [1:0]       pop_num;
    logic             do_push;

    // pop_1 never comes without pop_0
    assign pop_num = pop_0 ? (pop_1 ? 2'd2 : 2'd1) : 2'd0;
    assign do_push = push & ~full;

    // pointers wrap on their own since DEPTH is a power of two
    assign rd_ptr_1 = rd_ptr + 1'b1;

    assign head_0    = mem[rd_ptr];
    assign head_1    = mem[rd_ptr_1];
    assign head_0_ok = count != '0;
    assign head_1_ok = count > (PTR_W+1)'(1);
    assign full      = count == (PTR_W+1)'(DEPTH);

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            rd_ptr <= rd_ptr + PTR_W'(pop_num);
            count  <= count + (PTR_W+1)'(do_push) - (PTR_W+1)'(pop_num);
        end
    end

endmodule

//--- verilog/issue_top.sv
`timescale 1ns/1ps

module issue_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    push,
    input  issue_pkg::fetch_entry_t push_entry,
    input  logic                    stall,
    input  logic                    cls_refetch,
    output logic                    full,
    output issue_pkg::issue_slot_t  slot_0,
    output issue_pkg::issue_slot_t  slot_1
);

    issue_pkg::fetch_entry_t head_0;
    issue_pkg::fetch_entry_t head_1;
    issue_pkg::issue_slot_t  dec_0;
    issue_pkg::issue_slot_t  dec_1;
    logic                    head_0_ok;
    logic                    head_1_ok;
    logic                    pop_0;
    logic                    pop_1;

    inst_queue i_queue (
        .clk        (clk),
        .rst        (rst),
        .push       (push),
        .push_entry (push_entry),
        .pop_0      (pop_0),
        .pop_1      (pop_1),
        .head_0     (head_0),
        .head_1     (head_1),
        .head_0_ok  (head_0_ok),
        .head_1_ok  (head_1_ok),
        .full       (full)
    );

    // older entry
    inst_decoder i_decoder_0 (
        .entry (head_0),
        .slot  (dec_0)
    );

    inst_decoder i_decoder_1 (
        .entry (head_1),
        .slot  (dec_1)
    );

    dual_issue i_issue (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .cls_refetch (cls_refetch),
        .dec_0       (dec_0),
        .dec_1       (dec_1),
        .head_0_ok   (head_0_ok),
        .head_1_ok   (head_1_ok),
        .pop_0       (pop_0),
        .pop_1       (pop_1),
        .slot_0      (slot_0),
        .slot_1      (slot_1)
    );

endmodule
